// ==== sources.f ====
src/snake_pkg.sv
src/snake_body_if.sv
src/fruit_prbs.sv
src/snake_steering.sv
src/snake_body_store.sv
src/snake_game_fsm.sv
src/snake_game_top.sv
verif/snake_game_assert.sv
verif/snake_game_tb.sv

// ==== Bender.yml ====
package:
  name: snake_game

sources:
  # Package and interface first, the blocks depend on them
  - src/snake_pkg.sv
  - src/snake_body_if.sv
  - src/fruit_prbs.sv
  - src/snake_steering.sv
  - src/snake_body_store.sv
  - src/snake_game_fsm.sv
  - src/snake_game_top.sv
  - target: test
    files:
      - verif/snake_game_assert.sv
      - verif/snake_game_tb.sv

// ==== verif/snake_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_game_tb;
    import snake_pkg::*;

    localparam int timeout_cycles = 20000;  // About 60 ticks of at most ~300 cycles each
    localparam int wait_limit     = 300;    // One tick incl. fruit retries over an LFSR period of 127

    logic    clock_25, reset, game_tik, display_area, left_p, right_p, body_req;
    coord_t  head_x, head_y, fruit_x, fruit_y, body_x, body_y;
    score_t  score;
    length_t snake_length;
    logic    body_valid, ready, game_over;

    // Reference model
    coord_t     model_head_x, model_head_y;
    coord_t     model_fruit_x, model_fruit_y;
    coord_t     hist_x[$], hist_y[$];       // Earlier heads with the newest first
    heading_t   model_heading;
    logic [1:0] turn_delta;                 // 1 right, 3 left, 0 none
    score_t     model_score;
    length_t    model_length;

    int value_errors = 0;
    int other_errors = 0;
    int cycle_count  = 0;

    snake_game_top snake_game_top_inst (
        .clock_25     (clock_25),
        .reset        (reset),
        .game_tik     (game_tik),
        .display_area (display_area),
        .left_p       (left_p),
        .right_p      (right_p),
        .body_req     (body_req),
        .head_x       (head_x),
        .head_y       (head_y),
        .fruit_x      (fruit_x),
        .fruit_y      (fruit_y),
        .score        (score),
        .snake_length (snake_length),
        .body_x       (body_x),
        .body_y       (body_y),
        .body_valid   (body_valid),
        .ready        (ready),
        .game_over    (game_over)
    );

    initial begin
        clock_25 = 1'b0;
        forever #50 clock_25 = ~clock_25;   // 100 ns period
    end

    always @(posedge clock_25) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped, the tests did not finish within %0d cycles", timeout_cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_coord(input string name, input coord_t expected, input coord_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_score(input string name, input score_t expected, input score_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_length(input string name, input length_t expected,
                                input length_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0b, actual %0b", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clock_25);
        reset <= 1'b0;
        repeat (3) @(posedge clock_25);
        reset <= 1'b1;
        @(negedge clock_25);
    endtask

    // Start of game with five segments in a line left of the head
    task automatic model_reset();
        model_head_x  = 7'd8;
        model_head_y  = 7'd40;
        model_fruit_x = 7'd8;
        model_fruit_y = 7'd42;
        model_heading = head_right;
        turn_delta    = 2'd0;
        model_score   = 8'd0;
        model_length  = 5'd6;
        hist_x.delete();
        hist_y.delete();
        for (int i = 1; i < 6; i++) begin
            hist_x.push_back(coord_t'(8 - i));
            hist_y.push_back(7'd40);
        end
    endtask

    task automatic check_start_values(input string name);
        check_coord({name, " head x"}, 7'd8, head_x);
        check_coord({name, " head y"}, 7'd40, head_y);
        check_coord({name, " fruit x"}, 7'd8, fruit_x);
        check_coord({name, " fruit y"}, 7'd42, fruit_y);
        check_length({name, " length"}, 5'd6, snake_length);
        check_score({name, " score"}, 8'd0, score);
        check_flag({name, " game_over"}, 1'b0, game_over);
        check_flag({name, " ready"}, 1'b0, ready);
    endtask

    task automatic press_button(input logic go_right);
        @(posedge clock_25);
        if (go_right)
            right_p <= 1'b1;
        else
            left_p <= 1'b1;
        @(posedge clock_25);
        right_p <= 1'b0;                    // One-cycle pulse
        left_p  <= 1'b0;
        @(negedge clock_25);
    endtask

    task automatic turn(input logic go_right);
        press_button(go_right);
        turn_delta = go_right ? 2'd1 : 2'd3;    // Last press before the tick wins
    endtask

    // Returns once the DUT is ready again or has crashed
    task automatic wait_settled(input string name);
        int n;
        n = 0;
        while (!ready && !game_over && n < wait_limit) begin
            @(negedge clock_25);
            n++;
        end
        if (!ready && !game_over) begin
            $display("%s: ready never rose within %0d cycles", name, wait_limit);
            other_errors++;
        end
    endtask

    task automatic check_new_fruit(input string name);
        logic bad;
        bad = (fruit_x >= grid_cols) || (fruit_y >= grid_rows)
              || (fruit_x == model_head_x && fruit_y == model_head_y);
        for (int i = 0; i < hist_x.size(); i++)
            if (fruit_x == hist_x[i] && fruit_y == hist_y[i])
                bad = 1'b1;
        if (bad) begin
            $display("%s: new fruit at (%0d,%0d) is off the grid or on the snake",
                     name, fruit_x, fruit_y);
            other_errors++;
        end
        model_fruit_x = fruit_x;            // Model follows the random place
        model_fruit_y = fruit_y;
    endtask

    task automatic do_tick(input string name, output logic crash);
        int         nx, ny;
        int         keep;
        logic       ate, grow;
        logic [1:0] dir;
        dir           = model_heading + turn_delta;
        model_heading = heading_t'(dir);
        turn_delta    = 2'd0;
        nx = model_head_x;
        ny = model_head_y;
        case (model_heading)
            head_right: nx++;
            head_down:  ny++;               // y grows downward
            head_left:  nx--;
            default:    ny--;
        endcase
        crash = (nx < 0) || (ny < 0) || (nx >= grid_cols) || (ny >= grid_rows);
        ate   = 1'b0;
        if (!crash) begin                   // Wall crash leaves the head in place
            ate  = (nx == model_fruit_x) && (ny == model_fruit_y);
            grow = ate && (model_length < length_max);
            hist_x.push_front(model_head_x);
            hist_y.push_front(model_head_y);
            keep = grow ? model_length : model_length - 1;
            while (hist_x.size() > keep) begin
                void'(hist_x.pop_back());   // Tail drops off
                void'(hist_y.pop_back());
            end
            model_head_x = coord_t'(nx);
            model_head_y = coord_t'(ny);
            for (int i = 0; i < hist_x.size(); i++)
                if (hist_x[i] == model_head_x && hist_y[i] == model_head_y)
                    crash = 1'b1;
            if (!crash && ate) begin
                model_score++;
                if (grow)
                    model_length++;
            end
        end
        wait_settled(name);
        @(posedge clock_25);
        game_tik <= 1'b1;
        @(posedge clock_25);
        game_tik <= 1'b0;
        @(negedge clock_25);
        wait_settled(name);                 // Latency varies with fruit retries
        check_flag({name, " game_over"}, crash, game_over);
        check_coord({name, " head x"}, model_head_x, head_x);
        check_coord({name, " head y"}, model_head_y, head_y);
        check_score({name, " score"}, model_score, score);
        check_length({name, " length"}, model_length, snake_length);
        if (ate && !crash) begin
            check_new_fruit(name);
        end else begin
            check_coord({name, " fruit x"}, model_fruit_x, fruit_x);
            check_coord({name, " fruit y"}, model_fruit_y, fruit_y);
        end
    endtask

    task automatic test_reset_values();
        apply_reset();
        model_reset();
        check_start_values("reset");
        press_button(1'b1);                 // Start press is not latched as a turn
        wait_settled("reset start");
        check_flag("reset start ready", 1'b1, ready);
    endtask

    task automatic test_straight();
        logic crash;
        for (int i = 0; i < 5; i++)
            do_tick($sformatf("straight tick %0d", i), crash);
        check_coord("straight head x", 7'd13, head_x);
        check_coord("straight head y", 7'd40, head_y);
    endtask

    task automatic test_eating();
        logic crash;
        apply_reset();
        model_reset();
        press_button(1'b0);
        wait_settled("eat start");
        turn(1'b1);                         // Right to down
        do_tick("eat tick 0", crash);
        check_coord("eat first head y", 7'd41, head_y);
        do_tick("eat tick 1", crash);
        check_coord("eat head x", 7'd8, head_x);
        check_coord("eat head y", 7'd42, head_y);
        check_score("eat score", 8'd1, score);
        check_length("eat length", 5'd7, snake_length);
    endtask

    task automatic test_body_stream();
        int      cycles;
        length_t items;
        @(posedge clock_25);
        body_req <= 1'b1;
        @(posedge clock_25);
        body_req <= 1'b0;
        items  = 0;
        cycles = 0;
        while (cycles < 40) begin
            @(negedge clock_25);
            cycles++;
            if (body_valid) begin
                if (items < hist_x.size()) begin
                    check_coord($sformatf("stream seg %0d x", items), hist_x[items], body_x);
                    check_coord($sformatf("stream seg %0d y", items), hist_y[items], body_y);
                end
                items++;
            end else if (items != 0) begin
                break;
            end
        end
        if (cycles >= 40) begin
            $display("Body stream did not end within 40 cycles");
            other_errors++;
        end
        check_length("stream items", length_t'(model_length - 1), items);
    endtask

    task automatic test_self_crash();
        logic crash;
        for (int i = 0; i < 3; i++) begin
            turn(1'b1);                     // Three right turns close the loop
            do_tick($sformatf("self tick %0d", i), crash);
        end
        check_flag("self crash", 1'b1, game_over);
        @(posedge clock_25);
        game_tik <= 1'b1;                   // Ignored while game over
        @(posedge clock_25);
        game_tik <= 1'b0;
        repeat (3) @(negedge clock_25);
        check_coord("self stay x", model_head_x, head_x);
        check_coord("self stay y", model_head_y, head_y);
        check_flag("self still over", 1'b1, game_over);
        press_button(1'b1);                 // Back to idle
        repeat (2) @(negedge clock_25);
        model_reset();
        check_start_values("self restart");
    endtask

    task automatic test_wall_crash();
        logic crash;
        int   ticks;
        press_button(1'b1);
        wait_settled("wall start");
        check_flag("wall start ready", 1'b1, ready);
        turn(1'b0);                         // Right to up
        crash = 1'b0;
        ticks = 0;
        while (!crash && ticks < 60) begin
            do_tick($sformatf("wall tick %0d", ticks), crash);
            ticks++;
        end
        check_flag("wall game_over", 1'b1, game_over);
        check_coord("wall head x", 7'd8, head_x);
        check_coord("wall head y", 7'd0, head_y);
        check_score("wall score", 8'd0, score);
    endtask

    initial begin
        reset        = 1'b0;
        game_tik     = 1'b0;
        display_area = 1'b0;                // Blanking all the time
        left_p       = 1'b0;
        right_p      = 1'b0;
        body_req     = 1'b0;
        test_reset_values();
        test_straight();
        test_eating();
        test_body_stream();
        test_self_crash();
        test_wall_crash();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/snake_game_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_game_assert (
    input wire                    clock_25,
    input wire                    reset,
    input snake_pkg::game_state_t state,
    input snake_pkg::coord_t      head_x,
    input snake_pkg::coord_t      head_y,
    input snake_pkg::score_t      score,
    input snake_pkg::length_t     snake_length,
    input wire                    ready,
    input wire                    game_over
);
    import snake_pkg::*;

    // Score moves by one fruit at a time, the reload happens in st_idle
    assert property (@(posedge clock_25) disable iff (!reset)
        (score != $past(score)) && ($past(state) != st_idle) |-> score == $past(score) + 8'd1)
        else $error("score changed by something other than +1");

    assert property (@(posedge clock_25) disable iff (!reset)
        (head_x < grid_cols) && (head_y < grid_rows))
        else $error("head left the grid");          // Wall crash keeps the head in place

    assert property (@(posedge clock_25) disable iff (!reset)
        !(ready && game_over))
        else $error("ready and game_over high together");

    assert property (@(posedge clock_25) disable iff (!reset)
        snake_length <= length_max)
        else $error("snake length above its maximum");

endmodule

bind snake_game_fsm snake_game_assert snake_game_assert_inst (
    .clock_25     (clock_25),
    .reset        (reset),
    .state        (state),
    .head_x       (head_x),
    .head_y       (head_y),
    .score        (score),
    .snake_length (snake_length),
    .ready        (ready),
    .game_over    (game_over)
);

`default_nettype wire

// ==== src/snake_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_game_top (
    input  wire                 clock_25,
    input  wire                 reset,
    input  wire                 game_tik,
    input  wire                 display_area,
    input  wire                 left_p,
    input  wire                 right_p,
    input  wire                 body_req,
    output snake_pkg::coord_t   head_x,
    output snake_pkg::coord_t   head_y,
    output snake_pkg::coord_t   fruit_x,
    output snake_pkg::coord_t   fruit_y,
    output snake_pkg::score_t   score,
    output snake_pkg::length_t  snake_length,
    output snake_pkg::coord_t   body_x,
    output snake_pkg::coord_t   body_y,
    output logic                body_valid,
    output logic                ready,
    output logic                game_over
);
    import snake_pkg::*;

    game_state_t state;
    heading_t    heading;
    coord_t      rnd_x, rnd_y;              // Fruit candidates
    logic        armed, step, restart;

    // Steering control from the controller state
    assign armed   = (state != st_idle) && (state != st_collision);
    assign step    = (state == st_moving);
    assign restart = (state == st_idle);

    snake_body_if body_bus ();

    fruit_prbs fruit_prbs_x_inst (
        .clock_25 (clock_25),
        .reset    (reset),
        .seed     (7'h1c),
        .rnd      (rnd_x)
    );

    fruit_prbs fruit_prbs_y_inst (
        .clock_25 (clock_25),
        .reset    (reset),
        .seed     (7'h30),
        .rnd      (rnd_y)
    );

    snake_steering snake_steering_inst (
        .clock_25 (clock_25),
        .reset    (reset),
        .left_p   (left_p),
        .right_p  (right_p),
        .armed    (armed),
        .step     (step),
        .restart  (restart),
        .heading  (heading)
    );

    snake_body_store snake_body_store_inst (
        .clock_25   (clock_25),
        .body_req   (body_req),
        .body       (body_bus.store),
        .body_x     (body_x),
        .body_y     (body_y),
        .body_valid (body_valid)
    );

    snake_game_fsm snake_game_fsm_inst (
        .clock_25     (clock_25),
        .reset        (reset),
        .game_tik     (game_tik),
        .display_area (display_area),
        .left_p       (left_p),
        .right_p      (right_p),
        .heading      (heading),
        .rnd_x        (rnd_x),
        .rnd_y        (rnd_y),
        .body         (body_bus.ctrl),
        .state        (state),
        .head_x       (head_x),
        .head_y       (head_y),
        .fruit_x      (fruit_x),
        .fruit_y      (fruit_y),
        .score        (score),
        .snake_length (snake_length),
        .ready        (ready),
        .game_over    (game_over)
    );

endmodule

`default_nettype wire

// ==== src/snake_game_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_game_fsm (
    input  wire                    clock_25,
    input  wire                    reset,
    input  wire                    game_tik,        // One move per tick
    input  wire                    display_area,    // Commit only while low
    input  wire                    left_p,
    input  wire                    right_p,
    input  snake_pkg::heading_t    heading,
    input  snake_pkg::coord_t      rnd_x,
    input  snake_pkg::coord_t      rnd_y,
    snake_body_if.ctrl             body,
    output snake_pkg::game_state_t state,
    output snake_pkg::coord_t      head_x,
    output snake_pkg::coord_t      head_y,
    output snake_pkg::coord_t      fruit_x,
    output snake_pkg::coord_t      fruit_y,
    output snake_pkg::score_t      score,
    output snake_pkg::length_t     snake_length,
    output logic                   ready,
    output logic                   game_over
);
    import snake_pkg::*;

    game_state_t state_next;
    coord_t      next_x, next_y;            // Head after this move
    logic        off_grid;                  // Move would leave the grid
    logic        wall_hit;                  // Latched off_grid of the last move
    logic        press;
    logic        on_fruit;
    logic        fruit_bad;                 // Redraw needed

    assign press     = left_p | right_p;
    assign on_fruit  = (head_x == fruit_x) && (head_y == fruit_y);
    assign fruit_bad = (fruit_x >= grid_cols) || (fruit_y >= grid_rows) || body.fruit_on_body;

    // Next head from the heading, with the wall check
    always_comb begin
        next_x   = head_x;
        next_y   = head_y;
        off_grid = 1'b0;
        case (heading)
            head_right: begin
                if (head_x == coord_t'(grid_cols - 1)) off_grid = 1'b1;
                else next_x = head_x + 7'd1;
            end
            head_down: begin
                if (head_y == coord_t'(grid_rows - 1)) off_grid = 1'b1;
                else next_y = head_y + 7'd1;
            end
            head_left: begin
                if (head_x == 7'd0) off_grid = 1'b1;
                else next_x = head_x - 7'd1;
            end
            default: begin                  // head_up
                if (head_y == 7'd0) off_grid = 1'b1;
                else next_y = head_y - 7'd1;
            end
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            state <= st_idle;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle:         if (press) state_next = st_wait_tick;
            st_wait_tick:    if (game_tik) state_next = st_moving;
            st_moving:       state_next = st_move_done;
            st_move_done: begin
                if (wall_hit || body.body_hit)
                    state_next = st_collision;
                else if (on_fruit)
                    state_next = st_eaten_fruit;
                else if (!display_area)
                    state_next = st_wait_tick;
            end
            st_eaten_fruit:  state_next = st_fruit_update;
            st_fruit_update: if (!fruit_bad) state_next = st_fruit_done;
            st_fruit_done:   if (!display_area) state_next = st_wait_tick;
            st_collision:    if (press) state_next = st_idle;
            default:         state_next = st_idle;
        endcase
    end

    // Head, fruit, score and length
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head_x       <= begin_head_x;
            head_y       <= begin_head_y;
            fruit_x      <= begin_fruit_x;
            fruit_y      <= begin_fruit_y;
            score        <= 8'd0;
            snake_length <= begin_length;
            wall_hit     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin              // Held at start values until a press
                    head_x       <= begin_head_x;
                    head_y       <= begin_head_y;
                    fruit_x      <= begin_fruit_x;
                    fruit_y      <= begin_fruit_y;
                    score        <= 8'd0;
                    snake_length <= begin_length;
                    wall_hit     <= 1'b0;
                end
                st_moving: begin
                    wall_hit <= off_grid;
                    if (!off_grid) begin    // Head stays put on a wall crash
                        head_x <= next_x;
                        head_y <= next_y;
                    end
                end
                st_eaten_fruit: begin
                    score <= score + 8'd1;
                    if (snake_length < length_max)
                        snake_length <= snake_length + 5'd1;
                    fruit_x <= rnd_x;       // First draw
                    fruit_y <= rnd_y;
                end
                st_fruit_update: begin
                    if (fruit_bad) begin    // Retry with the next LFSR values
                        fruit_x <= rnd_x;
                        fruit_y <= rnd_y;
                    end
                end
                default: ;
            endcase
        end
    end

    // Body store control
    assign body.restart = (state == st_idle);
    assign body.step    = (state == st_moving);
    assign body.grow    = body.step && !off_grid && (next_x == fruit_x) && (next_y == fruit_y)
                          && (snake_length < length_max);
    assign body.head_x  = head_x;
    assign body.head_y  = head_y;
    assign body.fruit_x = fruit_x;
    assign body.fruit_y = fruit_y;
    assign body.length  = snake_length;

    assign ready     = (state == st_wait_tick);
    assign game_over = (state == st_collision);

endmodule

`default_nettype wire

// ==== src/snake_body_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_body_store (
    input  wire               clock_25,
    input  wire               body_req,     // Starts a body stream next cycle
    snake_body_if.store       body,
    output snake_pkg::coord_t body_x,
    output snake_pkg::coord_t body_y,
    output logic              body_valid
);
    import snake_pkg::*;

    localparam int seg_num = length_max - 1;    // Head is held by the controller

    coord_t             seg_x [seg_num];    // Segment 0 is next to the head
    coord_t             seg_y [seg_num];
    logic [seg_num-1:0] seg_valid;          // Live segments
    length_t            live_next;          // Live count after a step
    logic [3:0]         rd_idx;             // Stream position
    logic               rd_active;
    logic               rd_last;

    // Grow keeps the old tail, else the tail drops off
    assign live_next = body.grow ? body.length : body.length - 5'd1;

    // Segment coordinates shift toward the tail on each step
    always_ff @(posedge clock_25) begin
        if (body.restart) begin
            for (int i = 0; i < seg_num; i++) begin
                if (i < begin_length - 1) begin
                    seg_x[i] <= begin_head_x - coord_t'(i + 1);    // Trailing to the left
                    seg_y[i] <= begin_head_y;
                end
            end
        end else if (body.step) begin
            seg_x[0] <= body.head_x;        // Old head becomes segment 0
            seg_y[0] <= body.head_y;
            for (int i = 1; i < seg_num; i++) begin
                seg_x[i] <= seg_x[i-1];
                seg_y[i] <= seg_y[i-1];
            end
        end
    end

    // Valid mask loaded by restart and trimmed by each step
    always_ff @(posedge clock_25) begin
        if (body.restart) begin
            for (int i = 0; i < seg_num; i++)
                seg_valid[i] <= (i < begin_length - 1);
        end else if (body.step) begin
            for (int i = 0; i < seg_num; i++)
                seg_valid[i] <= (i < live_next);
        end
    end

    // Hit search over all live segments
    always_comb begin
        body.body_hit      = 1'b0;
        body.fruit_on_body = (body.fruit_x == body.head_x) && (body.fruit_y == body.head_y);
        for (int i = 0; i < seg_num; i++) begin
            if (seg_valid[i] && seg_x[i] == body.head_x && seg_y[i] == body.head_y)
                body.body_hit = 1'b1;
            if (seg_valid[i] && seg_x[i] == body.fruit_x && seg_y[i] == body.fruit_y)
                body.fruit_on_body = 1'b1;
        end
    end

    // Last item is segment length-2
    assign rd_last = ({1'b0, rd_idx} + 5'd2) >= body.length;

    // Readout where a new request restarts the stream
    always_ff @(posedge clock_25) begin
        if (body_req) begin
            rd_active <= 1'b1;
            rd_idx    <= 4'd0;
        end else if (body.restart) begin
            rd_active <= 1'b0;              // Also clears after power-up reset
            rd_idx    <= 4'd0;
        end else if (rd_active) begin
            if (rd_last)
                rd_active <= 1'b0;
            else
                rd_idx <= rd_idx + 4'd1;
        end
    end

    assign body_valid = rd_active;
    assign body_x     = seg_x[rd_idx];      // One segment per cycle without stall
    assign body_y     = seg_y[rd_idx];

endmodule

`default_nettype wire

// ==== src/snake_steering.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_steering (
    input  wire                 clock_25,
    input  wire                 reset,
    input  wire                 left_p,
    input  wire                 right_p,
    input  wire                 armed,      // High in the playing states
    input  wire                 step,       // Move happens on this edge
    input  wire                 restart,    // New game
    output snake_pkg::heading_t heading     // Heading for the next move
);
    import snake_pkg::*;

    heading_t heading_q;                    // Heading of the last move
    logic     left_d, right_d;              // Button history for edge detection
    logic     left_rise, right_rise;
    logic     turn_left, turn_right;        // Pending turn, at most one set

    assign left_rise  = left_p & ~left_d;
    assign right_rise = right_p & ~right_d;

    // Pending turn applied ahead of time, the controller reads this in st_moving
    always_comb begin
        if (turn_right)
            heading = heading_t'(heading_q + 2'd1);    // Clockwise
        else if (turn_left)
            heading = heading_t'(heading_q - 2'd1);    // Counter-clockwise
        else
            heading = heading_q;
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            heading_q  <= head_right;
            left_d     <= 1'b0;
            right_d    <= 1'b0;
            turn_left  <= 1'b0;
            turn_right <= 1'b0;
        end else begin
            left_d  <= left_p;
            right_d <= right_p;
            if (restart) begin
                heading_q  <= head_right;   // Start of game always faces right
                turn_left  <= 1'b0;
                turn_right <= 1'b0;
            end else begin
                if (step) begin
                    heading_q  <= heading;  // Commit the turn with the move
                    turn_left  <= 1'b0;
                    turn_right <= 1'b0;
                end
                // Last press wins, also one seen in the step cycle
                if (armed && right_rise) begin
                    turn_right <= 1'b1;
                    turn_left  <= 1'b0;
                end else if (armed && left_rise) begin
                    turn_left  <= 1'b1;
                    turn_right <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/fruit_prbs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fruit_prbs (
    input  wire               clock_25,
    input  wire               reset,
    input  snake_pkg::coord_t seed,         // Must be nonzero
    output snake_pkg::coord_t rnd
);

    logic feedback;

    // x^7 + x^6 + 1, period 127
    assign feedback = rnd[6] ^ rnd[5];

    // Runs every cycle, so each retry of the fruit sees a new value
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            rnd <= seed;                    // Loaded once per reset
        end else begin
            rnd <= {rnd[5:0], feedback};    // Shift in the feedback bit
        end
    end

    // The all-zero state is never entered from a nonzero seed

endmodule

`default_nettype wire

// ==== src/snake_body_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface snake_body_if;
    import snake_pkg::*;

    logic    restart;                       // Load the start body
    logic    step;                          // Shift old head into segment 0
    logic    grow;                          // Keep the tail on this step
    coord_t  head_x, head_y;                // Current head
    coord_t  fruit_x, fruit_y;              // Current fruit
    length_t length;                        // Snake length incl. head
    logic    body_hit;                      // Head sits on a live segment
    logic    fruit_on_body;                 // Fruit sits on head or a live segment

    modport ctrl (
        output restart, step, grow, head_x, head_y, fruit_x, fruit_y, length,
        input  body_hit, fruit_on_body
    );

    modport store (
        input  restart, step, grow, head_x, head_y, fruit_x, fruit_y, length,
        output body_hit, fruit_on_body
    );

endinterface

`default_nettype wire

// ==== src/snake_pkg.sv ====
`default_nettype none

package snake_pkg;

    // Basic cell and counter types
    typedef logic [6:0] coord_t;            // Cell coordinate, 0..127
    typedef logic [4:0] length_t;           // Segment count, 0..16
    typedef logic [7:0] score_t;            // Fruits eaten

    // Grid size in cells, 5x5 pixels each on a 620x405 game area
    localparam int grid_cols = 124;
    localparam int grid_rows = 81;

    localparam length_t length_max = 5'd16; // Head included

    // Start of a game
    localparam coord_t  begin_head_x  = 7'd8;
    localparam coord_t  begin_head_y  = 7'd40;
    localparam coord_t  begin_fruit_x = 7'd8;
    localparam coord_t  begin_fruit_y = 7'd42;
    localparam length_t begin_length  = 5'd6;

    // Game controller states
    typedef enum logic [2:0] {
        st_idle,                            // Start values loaded, waits for a press
        st_wait_tick,                       // Ready for the next game tick
        st_moving,                          // Head and body step on exit
        st_move_done,                       // Crash and fruit checks
        st_eaten_fruit,                     // Score, length and first fruit draw
        st_fruit_update,                    // Redraw while the fruit is badly placed
        st_fruit_done,                      // Waits for the blanking interval
        st_collision                        // Game over
    } game_state_t;

    // Clockwise order, so +1 is a right turn
    // y grows downward
    typedef enum logic [1:0] {
        head_right,
        head_down,
        head_left,
        head_up
    } heading_t;

endpackage

`default_nettype wire
